//--- Makefile
# Verilator build for the PCS reconfiguration sequencer testbench

TOP = tb_rcfg_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- hdl/rcfg_consts.svh
// PCS reconfiguration sequencer constants
// end-marker address, table geometry and PCS mode bit positions

`ifndef RCFG_CONSTS_SVH
`define RCFG_CONSTS_SVH

// table walk limits
`define RCFG_END_ADDR   10'h3FF
`define RCFG_TBL_DEPTH  7
`define RCFG_MAX_STEPS  8

// bit positions in the one-hot pcs mode
`define RCFG_MODE_AN    0
`define RCFG_MODE_LT    1
`define RCFG_MODE_TENG  2
`define RCFG_MODE_GIGE  3

// XAUI on bit 4 and 10G-FEC on bit 5 have no table in either variant
// so no position is defined for them here

`endif

//--- hdl/rcfg_ctrl_pkg.sv
// PCS reconfiguration control types
// state encoding of the table walking sequencer

package rcfg_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    RD_ISSUE,
    RD_WAIT,
    WR_ISSUE,
    NEXT,
    FINISH
  } rcfg_state_e;

endpackage

//--- hdl/rcfg_data_table.sv
// PCS reconfiguration data table
// Constant per-mode rows of {address, mask, data}, selected by the one-hot
// pcs mode with priority AN, LT, 10G, GigE. Backplane variant holds all
// four modes, lineside only 10G and GigE. Fully combinational.

`timescale 1ns/10ps

`include "rcfg_consts.svh"

module rcfg_data_table
  import rcfg_types_pkg::*;
#(
  parameter bit synth_an_lt = 1'b1
) (
  input  tbl_index_t   index,
  input  pcs_mode_t    pcs_mode,
  rcfg_entry_if.tbl    entry
);

  // row layout is address[25:16] mask[15:8] data[7:0]
  localparam logic [25:0] end_word = {`RCFG_END_ADDR, 8'hFF, 8'hFF};

  logic [25:0] word;
  logic [25:0] sel_word;
  logic        hit;
  logic        in_range;
  logic [2:0]  row;

  assign in_range = (index < tbl_index_t'(`RCFG_TBL_DEPTH));
  assign row      = index[2:0];

  generate
    if (synth_an_lt) begin : backplane
      //==========================================================================
      // backplane tables
      //==========================================================================
      localparam logic [25:0] an_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060703, 26'h0240705, 26'h037FF00, 26'h087E783,
        26'h13BFF00, 26'h13F0F07, 26'h3FFFFFF
      };
      localparam logic [25:0] lt_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060703, 26'h0240701, 26'h037FF00, 26'h087E743,
        26'h13BFF00, 26'h13F0F07, 26'h3FFFFFF
      };
      localparam logic [25:0] teng_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060703, 26'h0240701, 26'h037FF00, 26'h087E747,
        26'h13BFF00, 26'h13F0F07, 26'h3FFFFFF
      };
      localparam logic [25:0] gige_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060702, 26'h0240700, 26'h037FF01, 26'h087E740,
        26'h13BFF48, 26'h13F0F01, 26'h3FFFFFF
      };

      always_comb begin
        hit  = 1'b1;
        word = '0;
        if (pcs_mode[`RCFG_MODE_AN]) begin
          word = an_tbl[row];
        end else if (pcs_mode[`RCFG_MODE_LT]) begin
          word = lt_tbl[row];
        end else if (pcs_mode[`RCFG_MODE_TENG]) begin
          word = teng_tbl[row];
        end else if (pcs_mode[`RCFG_MODE_GIGE]) begin
          word = gige_tbl[row];
        end else begin
          hit = 1'b0;
        end
      end
    end else begin : lineside
      //==========================================================================
      // lineside tables, data modes only
      //==========================================================================
      localparam logic [25:0] teng_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060703, 26'h0240301, 26'h037FF00, 26'h0870707,
        26'h13BFF00, 26'h13F0F07, 26'h3FFFFFF
      };
      localparam logic [25:0] gige_tbl [`RCFG_TBL_DEPTH] = '{
        26'h0060702, 26'h0240300, 26'h037FF01, 26'h0870700,
        26'h13BFF48, 26'h13F0F01, 26'h3FFFFFF
      };

      always_comb begin
        hit  = 1'b1;
        word = '0;
        if (pcs_mode[`RCFG_MODE_TENG]) begin
          word = teng_tbl[row];
        end else if (pcs_mode[`RCFG_MODE_GIGE]) begin
          word = gige_tbl[row];
        end else begin
          hit = 1'b0;
        end
      end
    end
  endgenerate

  // rows past the depth read back as the end marker
  assign sel_word = !hit     ? '0   :
                    in_range ? word : end_word;

  assign entry.reg_addr  = sel_word[25:16];
  assign entry.mask      = sel_word[15:8];
  assign entry.data      = sel_word[7:0];
  assign entry.supported = hit;
  assign entry.last      = hit && (sel_word[25:16] == `RCFG_END_ADDR);

endmodule

//--- hdl/rcfg_entry_if.sv
// Reconfiguration table entry bus
// one table row as seen by the sequencer and the read-modify-write merge

`timescale 1ns/10ps

interface rcfg_entry_if
  import rcfg_types_pkg::*;
();

  dprio_addr_t reg_addr;
  dprio_byte_t mask;
  dprio_byte_t data;
  // row holds the end marker
  logic        last;
  // selected mode has a table in this variant
  logic        supported;

  modport tbl   (output reg_addr, mask, data, last, supported);
  modport seq   (input reg_addr, mask, last, supported);
  modport merge (input mask, data);

endinterface

//--- hdl/rcfg_rmw_merge.sv
// Read-modify-write merge
// Keeps the read byte outside the entry mask and substitutes the entry
// data under the mask. A full-mask entry bypasses the read path and
// writes the entry data directly.

`timescale 1ns/10ps

module rcfg_rmw_merge
  import rcfg_types_pkg::*;
(
  input  logic        mgmt_clk,
  input  logic        arst_n,
  input  logic        capture,
  input  logic        bypass,
  input  dprio_byte_t readdata,
  rcfg_entry_if.merge entry,
  output dprio_byte_t wdata
);

  dprio_byte_t merged_d;
  dprio_byte_t merged_q;

  // masked bits from the table, the rest from the register
  assign merged_d = (readdata & ~entry.mask) | (entry.data & entry.mask);

  always_ff @(posedge mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      merged_q <= '0;
    end else if (capture) begin
      merged_q <= merged_d;
    end
  end

  assign wdata = bypass ? entry.data : merged_q;

  // a full-mask entry must never reach the read phase
  a_no_capture_in_bypass: assert property (
    @(posedge mgmt_clk) disable iff (!arst_n) !(capture && bypass)
  );

endmodule

//--- hdl/rcfg_seq_fsm.sv
// Reconfiguration sequencer FSM
// Walks the table for the registered mode, one read-modify-write per
// entry on the register port. Strobes wait for the port busy to drop.
// Ends with a done pulse at the end marker, or an error pulse for an
// unsupported mode or a table overrun.

`timescale 1ns/10ps

module rcfg_seq_fsm
  import rcfg_types_pkg::*;
  import rcfg_ctrl_pkg::*;
(
  input  logic        mgmt_clk,
  input  logic        arst_n,
  input  logic        start,
  rcfg_entry_if.seq   entry,
  input  logic        overrun,
  input  dprio_byte_t wdata,
  input  logic        busy_in,
  input  logic        readdatavalid,
  output dprio_addr_t address,
  output dprio_byte_t writedata,
  output logic        read,
  output logic        write,
  output logic        clear,
  output logic        advance,
  output logic        capture,
  output logic        bypass,
  output logic        seq_busy,
  output logic        done,
  output logic        error
);

  rcfg_state_e state_q;
  rcfg_state_e state_d;
  logic        fetch_err;
  logic        full_mask;
  logic        done_q;
  logic        error_q;

  assign fetch_err = !entry.supported || overrun;
  assign full_mask = (entry.mask == 8'hFF);

  //============================================================================
  // next state and strobes
  //============================================================================
  always_comb begin
    state_d = state_q;
    clear   = 1'b0;
    advance = 1'b0;
    read    = 1'b0;
    write   = 1'b0;
    capture = 1'b0;
    case (state_q)
      IDLE: begin
        if (start) begin
          clear   = 1'b1;
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (fetch_err || entry.last) begin
          state_d = FINISH;
        end else if (full_mask) begin
          state_d = WR_ISSUE;
        end else begin
          state_d = RD_ISSUE;
        end
      end
      RD_ISSUE: begin
        if (!busy_in) begin
          read    = 1'b1;
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (readdatavalid) begin
          capture = 1'b1;
          state_d = WR_ISSUE;
        end
      end
      WR_ISSUE: begin
        if (!busy_in) begin
          write   = 1'b1;
          state_d = NEXT;
        end
      end
      NEXT: begin
        advance = 1'b1;
        state_d = FETCH;
      end
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  //============================================================================
  // state and completion pulses
  //============================================================================
  always_ff @(posedge mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // both land in the single FINISH cycle
      error_q <= (state_q == FETCH) && fetch_err;
      done_q  <= (state_q == FETCH) && !fetch_err && entry.last;
    end
  end

  assign address   = entry.reg_addr;
  assign writedata = wdata;
  assign bypass    = full_mask;
  assign seq_busy  = (state_q != IDLE);
  assign done      = done_q;
  assign error     = error_q;

  // register port rules
  a_rd_wr_excl: assert property (
    @(posedge mgmt_clk) disable iff (!arst_n) !(read && write)
  );
  a_no_strobe_when_busy: assert property (
    @(posedge mgmt_clk) disable iff (!arst_n) (read || write) |-> !busy_in
  );

endmodule

//--- hdl/rcfg_step_counter.sv
// Table step counter
// row index for the table walk, cleared at run start and advanced once
// per finished entry; flags an overrun past the step limit

`timescale 1ns/10ps

`include "rcfg_consts.svh"

module rcfg_step_counter
  import rcfg_types_pkg::*;
(
  input  logic       mgmt_clk,
  input  logic       arst_n,
  input  logic       clear,
  input  logic       advance,
  output tbl_index_t index,
  output logic       overrun
);

  always_ff @(posedge mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;
    end else if (advance) begin
      index <= index + tbl_index_t'(1);
    end
  end

  // table never ended within the step limit
  assign overrun = (index >= tbl_index_t'(`RCFG_MAX_STEPS));

  // sequencer issues at most one counter command per cycle
  a_clear_advance_excl: assert property (
    @(posedge mgmt_clk) disable iff (!arst_n) !(clear && advance)
  );

endmodule

//--- hdl/rcfg_top.sv
// PCS reconfiguration sequencer top level
// Registers the requested mode at start, then walks the per-mode table
// with read-modify-writes on the DPRIO style register port.
// synth_an_lt selects the backplane (1) or lineside (0) table set.

`timescale 1ns/10ps

module rcfg_top
  import rcfg_types_pkg::*;
#(
  parameter bit synth_an_lt = 1'b1
) (
  input  logic        mgmt_clk,
  input  logic        arst_n,
  input  logic        start,
  input  pcs_mode_t   pcs_mode,
  input  dprio_byte_t rcfg_readdata,
  input  logic        rcfg_readdatavalid,
  input  logic        rcfg_busy,
  output dprio_addr_t rcfg_address,
  output dprio_byte_t rcfg_writedata,
  output logic        rcfg_read,
  output logic        rcfg_write,
  output logic        seq_busy,
  output logic        done,
  output logic        error
);

  pcs_mode_t   mode_q;
  tbl_index_t  index;
  logic        clear;
  logic        advance;
  logic        overrun;
  logic        capture;
  logic        bypass;
  dprio_byte_t wdata;

  rcfg_entry_if entry_if_i ();

  // mode held for the whole run, start ignored while busy
  always_ff @(posedge mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      mode_q <= '0;
    end else if (start && !seq_busy) begin
      mode_q <= pcs_mode;
    end
  end

  rcfg_data_table #(
    .synth_an_lt (synth_an_lt)
  ) table_i (
    .index    (index),
    .pcs_mode (mode_q),
    .entry    (entry_if_i.tbl)
  );

  rcfg_step_counter counter_i (
    .mgmt_clk (mgmt_clk),
    .arst_n   (arst_n),
    .clear    (clear),
    .advance  (advance),
    .index    (index),
    .overrun  (overrun)
  );

  rcfg_rmw_merge merge_i (
    .mgmt_clk (mgmt_clk),
    .arst_n   (arst_n),
    .capture  (capture),
    .bypass   (bypass),
    .readdata (rcfg_readdata),
    .entry    (entry_if_i.merge),
    .wdata    (wdata)
  );

  rcfg_seq_fsm fsm_i (
    .mgmt_clk      (mgmt_clk),
    .arst_n        (arst_n),
    .start         (start),
    .entry         (entry_if_i.seq),
    .overrun       (overrun),
    .wdata         (wdata),
    .busy_in       (rcfg_busy),
    .readdatavalid (rcfg_readdatavalid),
    .address       (rcfg_address),
    .writedata     (rcfg_writedata),
    .read          (rcfg_read),
    .write         (rcfg_write),
    .clear         (clear),
    .advance       (advance),
    .capture       (capture),
    .bypass        (bypass),
    .seq_busy      (seq_busy),
    .done          (done),
    .error         (error)
  );

endmodule

//--- hdl/rcfg_types_pkg.sv
// PCS reconfiguration data types
// vector types for the register port, the data table and the PCS mode

package rcfg_types_pkg;

  // register port address (DPRIO offset)
  typedef logic [9:0] dprio_addr_t;

  // register data, rmw mask and merged write byte
  typedef logic [7:0] dprio_byte_t;

  // row index into a per-mode table
  typedef logic [5:0] tbl_index_t;

  // one-hot pcs mode
  //   bit 0  AN
  //   bit 1  LT
  //   bit 2  10G
  //   bit 3  GigE
  //   bit 4  XAUI
  //   bit 5  10G-FEC
  typedef logic [5:0] pcs_mode_t;

endpackage

//--- tb/dprio_reg_model.sv
// DPRIO register port model
// 1024 byte register space, reads answered after a random latency,
// random busy stretches, every write reported as a one-cycle event

`timescale 1ns/10ps

module dprio_reg_model
  import rcfg_types_pkg::*;
(
  input  logic        mgmt_clk,
  input  logic        arst_n,
  input  logic        read,
  input  logic        write,
  input  dprio_addr_t address,
  input  dprio_byte_t writedata,
  output dprio_byte_t readdata,
  output logic        readdatavalid,
  output logic        busy,
  output logic        wr_evt,
  output dprio_addr_t wr_addr,
  output dprio_byte_t wr_data,
  output int          rd_count
);

  dprio_byte_t mem [0:1023];
  integer      seed;
  logic        rd_seen;
  logic        wr_seen;
  dprio_addr_t addr_seen;
  dprio_byte_t data_seen;
  logic        pending;
  int          countdown;
  dprio_addr_t raddr;
  int          busy_left;

  // fill byte mixed with the address, upper bits included
  task automatic fill_mem(input dprio_byte_t fill);
    dprio_addr_t a;
    for (int i = 0; i < 1024; i++) begin
      a = dprio_addr_t'(i);
      mem[i] = fill ^ a[7:0] ^ {6'b0, a[9:8]};
    end
  endtask

  // strobes are stable mid-cycle
  always @(negedge mgmt_clk) begin
    rd_seen   = read;
    wr_seen   = write;
    addr_seen = address;
    data_seen = writedata;
  end

  initial begin
    seed          = 95;
    readdata      = '0;
    readdatavalid = 1'b0;
    busy          = 1'b0;
    wr_evt        = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    rd_count      = 0;
    pending       = 1'b0;
    countdown     = 0;
    raddr         = '0;
    busy_left     = 0;
    forever begin
      @(posedge mgmt_clk);
      #1;
      readdatavalid = 1'b0;
      wr_evt        = 1'b0;
      if (arst_n) begin
        if (wr_seen) begin
          mem[addr_seen] = data_seen;
          wr_evt  = 1'b1;
          wr_addr = addr_seen;
          wr_data = data_seen;
        end
        // answer an outstanding read
        if (pending) begin
          countdown = countdown - 1;
          if (countdown == 0) begin
            readdata      = mem[raddr];
            readdatavalid = 1'b1;
            pending       = 1'b0;
          end
        end
        if (rd_seen) begin
          rd_count  = rd_count + 1;
          pending   = 1'b1;
          countdown = 1 + ({$random(seed)} % 4);
          raddr     = addr_seen;
        end
        if (busy_left > 0) begin
          busy      = 1'b1;
          busy_left = busy_left - 1;
        end else begin
          busy = 1'b0;
          if ({$random(seed)} % 3 == 0) begin
            busy_left = {$random(seed)} % 3;
          end
        end
      end
    end
  end

endmodule

//--- tb/rcfg_vectors.txt
// header word: status[31:28] (1 done, 2 error), writes[27:24], reads[23:20],
// fill[15:8], pcs mode[5:0]; then six write words {address[25:16], data[7:0]}
@0
00000007
// AN, fill 5a
16405A01
0006005B 0024007D 00370000 0087009B 013B0000 013F0067
// LT, fill c3
1640C302
000600C3 002400E1 00370000 00870043 013B0000 013F00F7
// 10G, fill 00
16400004
00060003 00240021 00370000 00870047 013B0000 013F0037
// GigE, fill ff
1640FF08
000600FA 002400D8 00370001 00870058 013B0048 013F00C1
// XAUI, fill 11
20001110
00000000 00000000 00000000 00000000 00000000 00000000
// 10G-FEC, fill 22
20002220
00000000 00000000 00000000 00000000 00000000 00000000
// no mode bit set, fill 33
20003300
00000000 00000000 00000000 00000000 00000000 00000000

//--- tb/tb_rcfg_top.sv
// PCS reconfiguration sequencer testbench
// runs every test of the vector file against the backplane variant and
// checks write order, merged data, read count and final status

`timescale 1ns/10ps

`include "rcfg_consts.svh"

module tb_rcfg_top
  import rcfg_types_pkg::*;
();

  localparam int rec_words = 7;

  logic        mgmt_clk;
  logic        arst_n;
  logic        start;
  pcs_mode_t   pcs_mode;
  dprio_byte_t rcfg_readdata;
  logic        rcfg_readdatavalid;
  logic        rcfg_busy;
  dprio_addr_t rcfg_address;
  dprio_byte_t rcfg_writedata;
  logic        rcfg_read;
  logic        rcfg_write;
  logic        seq_busy;
  logic        done;
  logic        error;
  logic        wr_evt;
  dprio_addr_t wr_addr;
  dprio_byte_t wr_data;
  int          rd_count;

  logic [31:0] vec_mem [0:63];
  int          n_tests;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        before_first = 1'b1;

  rcfg_top #(
    .synth_an_lt (1'b1)
  ) dut_i (
    .mgmt_clk           (mgmt_clk),
    .arst_n             (arst_n),
    .start              (start),
    .pcs_mode           (pcs_mode),
    .rcfg_readdata      (rcfg_readdata),
    .rcfg_readdatavalid (rcfg_readdatavalid),
    .rcfg_busy          (rcfg_busy),
    .rcfg_address       (rcfg_address),
    .rcfg_writedata     (rcfg_writedata),
    .rcfg_read          (rcfg_read),
    .rcfg_write         (rcfg_write),
    .seq_busy           (seq_busy),
    .done               (done),
    .error              (error)
  );

  dprio_reg_model model_i (
    .mgmt_clk      (mgmt_clk),
    .arst_n        (arst_n),
    .read          (rcfg_read),
    .write         (rcfg_write),
    .address       (rcfg_address),
    .writedata     (rcfg_writedata),
    .readdata      (rcfg_readdata),
    .readdatavalid (rcfg_readdatavalid),
    .busy          (rcfg_busy),
    .wr_evt        (wr_evt),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_count      (rd_count)
  );

  initial mgmt_clk = 1'b0;
  always #2 mgmt_clk = ~mgmt_clk;

  //==========================================================================
  // failure reporting and compare tasks
  //==========================================================================
  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input dprio_addr_t got,
                            input dprio_addr_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input dprio_byte_t got,
                            input dprio_byte_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_stop($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  // status 1 wants one done pulse, status 2 one error pulse
  task automatic check_status(input logic [3:0] exp, input int n_done,
                              input int n_err);
    int exp_done;
    int exp_err;
    exp_done = (exp == 4'h1) ? 1 : 0;
    exp_err  = (exp == 4'h2) ? 1 : 0;
    if (n_done != exp_done || n_err != exp_err) begin
      fail_stop($sformatf("[FAIL] done/error got %h/%h expected %h/%h",
                          n_done, n_err, exp_done, exp_err));
    end
  endtask

  //==========================================================================
  // monitors
  //==========================================================================
  always @(negedge mgmt_clk) begin
    if (arst_n && rcfg_busy && (rcfg_read || rcfg_write)) begin
      fail_stop("register port strobe issued while the port was busy");
    end
    if (before_first && (rcfg_read || rcfg_write || done || error || seq_busy)) begin
      fail_stop("sequencer output active before the first start");
    end
  end

  always @(posedge mgmt_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      fail_stop("timeout, sequencer never finished its runs");
    end
  end

  // one vector record, start pulse plus a stray start mid-run for 10G
  task automatic run_test(input int t);
    logic [31:0] hdr;
    logic [31:0] w;
    logic [3:0]  status;
    dprio_byte_t fill;
    pcs_mode_t   mode;
    int          base;
    int          n_wr;
    int          n_rd;
    int          rd_start;
    int          wr_idx;
    int          n_done;
    int          n_err;
    int          waited;
    int          tail;
    base   = 1 + t * rec_words;
    hdr    = vec_mem[base];
    status = hdr[31:28];
    n_wr   = int'(hdr[27:24]);
    n_rd   = int'(hdr[23:20]);
    fill   = hdr[15:8];
    mode   = hdr[5:0];
    model_i.fill_mem(fill);
    rd_start = rd_count;
    wr_idx   = 0;
    n_done   = 0;
    n_err    = 0;
    waited   = 0;
    tail     = 0;
    @(posedge mgmt_clk);
    #1;
    start        = 1'b1;
    pcs_mode     = mode;
    before_first = 1'b0;
    while (tail < 4) begin
      @(posedge mgmt_clk);
      #1;
      start    = (t == 2 && waited == 4) ? 1'b1 : 1'b0;
      pcs_mode = (t == 2 && waited == 4) ? 6'b001000 : 6'b000000;
      @(negedge mgmt_clk);
      waited = waited + 1;
      if (wr_evt) begin
        if (wr_idx >= n_wr) begin
          fail_stop("write seen beyond the expected sequence");
        end
        w = vec_mem[base + 1 + wr_idx];
        check_addr("rcfg_address", wr_addr, w[25:16]);
        check_byte("rcfg_writedata", wr_data, w[7:0]);
        wr_idx = wr_idx + 1;
      end
      // busy from the cycle after start through the done or error cycle
      check_flag("seq_busy", seq_busy, (n_done + n_err == 0));
      if (done) begin
        n_done = n_done + 1;
      end
      if (error) begin
        n_err = n_err + 1;
      end
      if (n_done + n_err > 0) begin
        tail = tail + 1;
      end
    end
    check_count("write count", wr_idx, n_wr);
    check_count("read count", rd_count - rd_start, n_rd);
    check_status(status, n_done, n_err);
  endtask

  initial begin
    arst_n   = 1'b0;
    start    = 1'b0;
    pcs_mode = '0;
    $readmemh("tb/rcfg_vectors.txt", vec_mem);
    n_tests = int'(vec_mem[0]);
    if (n_tests <= 0 || n_tests > 9) begin
      fail_stop("vector file missing or holds a bad test count");
    end
    cycle_limit = n_tests * `RCFG_TBL_DEPTH * 12 + 200;
    repeat (5) @(posedge mgmt_clk);
    #1;
    arst_n = 1'b1;
    // idle outputs are watched by the monitor until the first start
    repeat (5) @(posedge mgmt_clk);
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/rcfg_types_pkg.sv
hdl/rcfg_ctrl_pkg.sv
hdl/rcfg_entry_if.sv
hdl/rcfg_data_table.sv
hdl/rcfg_step_counter.sv
hdl/rcfg_rmw_merge.sv
hdl/rcfg_seq_fsm.sv
hdl/rcfg_top.sv
tb/dprio_reg_model.sv
tb/tb_rcfg_top.sv
